//--- build.f
verilog/fma_pkg.sv
verilog/fma_special_case.sv
verilog/fma_core.sv
verilog/fma_latency_timer.sv
verilog/fma_sequencer.sv
verilog/fma_fcsr.sv
verilog/fma_unit.sv
tests/tb_fma_unit.sv

//--- Makefile
# Verilator build and run for the FMA unit testbench

VERILATOR ?= verilator
TOP       ?= tb_fma_unit
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= PASS: all tests
VFLAGS    ?= --binary --timing

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_fma_unit.sv
`timescale 1ns/100ps

module tb_fma_unit;
    import fma_pkg::*;

    localparam int LATENCY       = 3;
    localparam int CLK_HALF      = 4;
    localparam int DRIVE_DELAY   = 1;
    localparam int NUM_OPS       = 28;
    localparam int CYCLES_PER_OP = 200;
    localparam int READY_LIMIT   = 100;

    // Binary32 operands
    localparam fp32_t ZERO     = 32'h00000000;
    localparam fp32_t ONE      = 32'h3f800000;
    localparam fp32_t NEG_ONE  = 32'hbf800000;
    localparam fp32_t ONE_P5   = 32'h3fc00000;
    localparam fp32_t TWO      = 32'h40000000;
    localparam fp32_t THREE    = 32'h40400000;
    localparam fp32_t HALF     = 32'h3f000000;
    localparam fp32_t EPS_HALF = 32'h33800000;
    localparam fp32_t EPS_NEG  = 32'hb3800000;
    localparam fp32_t EPS_1P5  = 32'h33c00000;
    localparam fp32_t MIN_NORM = 32'h00800000;
    localparam fp32_t MAX_FIN  = 32'h7f7fffff;
    localparam fp32_t POS_INF  = 32'h7f800000;
    localparam fp32_t NEG_INF  = 32'hff800000;
    localparam fp32_t QNAN     = 32'h7fc12345;
    localparam fp32_t NAN_OUT  = 32'h7fc00000;

    // Flag masks, NV DZ OF UF NX
    localparam fflags_t F_NONE = 5'h00;
    localparam fflags_t F_NV   = 5'h10;
    localparam fflags_t F_OF   = 5'h04;
    localparam fflags_t F_UF   = 5'h02;
    localparam fflags_t F_NX   = 5'h01;

    logic    clk_i;
    logic    rst_i;
    logic    req_i;
    fp32_t   a_i;
    fp32_t   b_i;
    fp32_t   c_i;
    rm_t     rm_i;
    logic    stall_i;
    logic    csr_we_i;
    fcsr_t   csr_wdata_i;
    logic    ready_o;
    logic    busy_o;
    fp32_t   result_o;
    fflags_t flags_o;
    logic    illegal_rm_o;
    fcsr_t   fcsr_o;

    fma_unit #(
        .FMA_LATENCY (LATENCY)
    ) fma_unit_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (req_i),
        .a_i          (a_i),
        .b_i          (b_i),
        .c_i          (c_i),
        .rm_i         (rm_i),
        .stall_i      (stall_i),
        .csr_we_i     (csr_we_i),
        .csr_wdata_i  (csr_wdata_i),
        .ready_o      (ready_o),
        .busy_o       (busy_o),
        .result_o     (result_o),
        .flags_o      (flags_o),
        .illegal_rm_o (illegal_rm_o),
        .fcsr_o       (fcsr_o)
    );

    always #CLK_HALF clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%08h expected 0x%08h",
                                name, got, expected));
        end
    endtask

    // Inputs change just after the edge
    task automatic next_cycle();
        @(posedge clk_i);
        #DRIVE_DELAY;
    endtask

    task automatic issue_op(input fp32_t a, input fp32_t b, input fp32_t c, input rm_t rm);
        a_i   = a;
        b_i   = b;
        c_i   = c;
        rm_i  = rm;
        req_i = 1'b1;
        next_cycle();
        req_i = 1'b0;
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready_o) begin
            if (n == READY_LIMIT) begin
                abort_run("Timeout: ready_o never rose after a request");
            end
            next_cycle();
            n++;
        end
    endtask

    // Full operation, stall low, result taken in the ready cycle
    task automatic run_op(input fp32_t a, input fp32_t b, input fp32_t c, input rm_t rm,
                          input fp32_t exp_value, input fflags_t exp_flags);
        issue_op(a, b, c, rm);
        wait_ready();
        check_value("result_o", result_o, exp_value);
        check_value("flags_o", 32'(flags_o), 32'(exp_flags));
        check_value("illegal_rm_o", 32'(illegal_rm_o), 32'd0);
        next_cycle();
    endtask

    task automatic write_fcsr(input rm_t frm, input fflags_t flags);
        csr_wdata_i = '{frm: frm, fflags: flags};
        csr_we_i    = 1'b1;
        next_cycle();
        csr_we_i    = 1'b0;
        check_value("fcsr_o", 32'(fcsr_o), 32'({frm, flags}));
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////
    task automatic test_exact();
        run_op(ONE_P5, TWO, THREE, RM_RNE, 32'h40f00000, F_NONE);
        // Exact cancellation sign depends on the mode
        run_op(ONE, NEG_ONE, ONE, RM_RNE, 32'h00000000, F_NONE);
        run_op(ONE, NEG_ONE, ONE, RM_RDN, 32'h80000000, F_NONE);
    endtask

    task automatic test_tie_rounding();
        // 1 + 2^-24 sits halfway between two neighbours
        run_op(ONE, EPS_HALF, ONE, RM_RNE, 32'h3f800000, F_NX);
        run_op(ONE, EPS_HALF, ONE, RM_RTZ, 32'h3f800000, F_NX);
        run_op(ONE, EPS_HALF, ONE, RM_RDN, 32'h3f800000, F_NX);
        run_op(ONE, EPS_HALF, ONE, RM_RUP, 32'h3f800001, F_NX);
        run_op(ONE, EPS_HALF, ONE, RM_RMM, 32'h3f800001, F_NX);
        run_op(NEG_ONE, EPS_NEG, ONE, RM_RDN, 32'hbf800001, F_NX);
    endtask

    task automatic test_special_values();
        run_op(ONE, POS_INF, ZERO, RM_RNE, NAN_OUT, F_NV);
        run_op(ONE, QNAN, TWO, RM_RNE, NAN_OUT, F_NONE);
        run_op(POS_INF, NEG_INF, ONE, RM_RNE, NAN_OUT, F_NV);
        // 2^-127 is an exact denormal
        run_op(ZERO, MIN_NORM, HALF, RM_RNE, 32'h00400000, F_NONE);
        // 1.5 * 2^-150 rounds up to the smallest denormal
        run_op(ZERO, MIN_NORM, EPS_1P5, RM_RNE, 32'h00000001, F_UF | F_NX);
    endtask

    task automatic test_overflow();
        run_op(ZERO, MAX_FIN, TWO, RM_RNE, POS_INF, F_OF | F_NX);
        run_op(ZERO, MAX_FIN, TWO, RM_RUP, POS_INF, F_OF | F_NX);
        run_op(ZERO, MAX_FIN, TWO, RM_RTZ, MAX_FIN, F_OF | F_NX);
        run_op(ZERO, MAX_FIN, TWO, RM_RDN, MAX_FIN, F_OF | F_NX);
    endtask

    task automatic test_control_register();
        write_fcsr(RM_RUP, F_NONE);
        run_op(ONE, EPS_HALF, ONE, RM_DYN, 32'h3f800001, F_NX);
        write_fcsr(RM_RNE, F_NONE);
        // Flags collect over several operations
        run_op(ONE_P5, TWO, THREE, RM_RNE, 32'h40f00000, F_NONE);
        write_fcsr(RM_RNE, F_NONE);
        run_op(ONE, EPS_HALF, ONE, RM_RNE, 32'h3f800000, F_NX);
        run_op(ONE, POS_INF, ZERO, RM_RNE, NAN_OUT, F_NV);
        run_op(ONE_P5, TWO, THREE, RM_RNE, 32'h40f00000, F_NONE);
        check_value("fcsr_o", 32'(fcsr_o), 32'({RM_RNE, F_NV | F_NX}));
        write_fcsr(RM_RNE, F_NONE);
        // Reserved mode completes with a NaN and leaves fflags alone
        issue_op(ONE, EPS_HALF, ONE, 3'b101);
        wait_ready();
        check_value("illegal_rm_o", 32'(illegal_rm_o), 32'd1);
        check_value("result_o", result_o, NAN_OUT);
        check_value("flags_o", 32'(flags_o), 32'(F_NONE));
        next_cycle();
        run_op(ONE_P5, TWO, THREE, RM_RNE, 32'h40f00000, F_NONE);
        check_value("fcsr_o", 32'(fcsr_o), 32'({RM_RNE, F_NONE}));
    endtask

    task automatic test_timing();
        int cycles;
        a_i    = ONE_P5;
        b_i    = TWO;
        c_i    = THREE;
        rm_i   = RM_RNE;
        req_i  = 1'b1;
        cycles = 0;
        do begin
            next_cycle();
            cycles++;
            if (cycles > READY_LIMIT) begin
                abort_run("Timeout: ready_o never rose in the timing test");
            end
            if (!ready_o) begin
                check_value("busy_o", 32'(busy_o), 32'd1);
            end
            // A second request in mid flight must be dropped
            req_i = (cycles == 2) && !ready_o;
            if (cycles == 2) begin
                a_i = ZERO;
                b_i = MAX_FIN;
            end
        end while (!ready_o);
        check_value("ready delay", 32'(cycles), 32'(LATENCY + 1));
        check_value("result_o", result_o, 32'h40f00000);
        check_value("flags_o", 32'(flags_o), 32'(F_NONE));
        repeat (5) begin
            next_cycle();
            check_value("ready_o", 32'(ready_o), 32'd0);
            check_value("busy_o", 32'(busy_o), 32'd0);
        end
    endtask

    task automatic test_stall();
        write_fcsr(RM_RNE, F_NONE);
        issue_op(ONE, EPS_HALF, ONE, RM_RNE);
        wait_ready();
        // Flags of this operation show in the first ready cycle
        check_value("fcsr_o", 32'(fcsr_o), 32'({RM_RNE, F_NX}));
        stall_i = 1'b1;
        repeat (3) begin
            next_cycle();
            check_value("ready_o", 32'(ready_o), 32'd1);
            check_value("result_o", result_o, 32'h3f800000);
            check_value("flags_o", 32'(flags_o), 32'(F_NX));
        end
        // Cleared flags stay clear while the result is held
        write_fcsr(RM_RNE, F_NONE);
        repeat (3) begin
            next_cycle();
            check_value("ready_o", 32'(ready_o), 32'd1);
            check_value("result_o", result_o, 32'h3f800000);
            check_value("flags_o", 32'(flags_o), 32'(F_NX));
            check_value("fcsr_o", 32'(fcsr_o), 32'({RM_RNE, F_NONE}));
        end
        stall_i = 1'b0;
        next_cycle();
        check_value("ready_o", 32'(ready_o), 32'd0);
        run_op(ONE_P5, TWO, THREE, RM_RNE, 32'h40f00000, F_NONE);
        check_value("fcsr_o", 32'(fcsr_o), 32'({RM_RNE, F_NONE}));
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        #(2 * CLK_HALF * CYCLES_PER_OP * NUM_OPS);
        abort_run("Watchdog: the tests did not finish in time");
    end

    initial begin
        clk_i       = 1'b0;
        rst_i       = 1'b1;
        req_i       = 1'b0;
        a_i         = ZERO;
        b_i         = ZERO;
        c_i         = ZERO;
        rm_i        = RM_RNE;
        stall_i     = 1'b0;
        csr_we_i    = 1'b0;
        csr_wdata_i = '0;
        repeat (8) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_i = 1'b0;
        check_value("ready_o", 32'(ready_o), 32'd0);
        check_value("busy_o", 32'(busy_o), 32'd0);
        check_value("illegal_rm_o", 32'(illegal_rm_o), 32'd0);
        check_value("fcsr_o", 32'(fcsr_o), 32'd0);
        test_exact();
        test_tie_rounding();
        test_special_values();
        test_overflow();
        test_control_register();
        test_timing();
        test_stall();
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- verilog/fma_unit.sv
`timescale 1ns/100ps

module fma_unit #(
    parameter int FMA_LATENCY = 3
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             req_i,
    input  fma_pkg::fp32_t   a_i,
    input  fma_pkg::fp32_t   b_i,
    input  fma_pkg::fp32_t   c_i,
    input  fma_pkg::rm_t     rm_i,
    input  logic             stall_i,
    input  logic             csr_we_i,
    input  fma_pkg::fcsr_t   csr_wdata_i,
    output logic             ready_o,
    output logic             busy_o,
    output fma_pkg::fp32_t   result_o,
    output fma_pkg::fflags_t flags_o,
    output logic             illegal_rm_o,
    output fma_pkg::fcsr_t   fcsr_o
);
    import fma_pkg::*;

    fma_operands_t ops_q;
    fma_result_t   core_result;
    fma_result_t   result_q;
    rm_t           rm_eff;
    logic          rm_illegal;
    logic          illegal_q;
    logic          accept;
    logic          capture;
    logic          expired;
    logic          accrue;

    // Illegal mode completes without touching fflags
    assign accrue = capture & !illegal_q;

    fma_fcsr fma_fcsr_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .csr_we_i     (csr_we_i),
        .csr_wdata_i  (csr_wdata_i),
        .rm_i         (rm_i),
        .accrue_i     (accrue),
        .flags_i      (core_result.flags),
        .rm_eff_o     (rm_eff),
        .rm_illegal_o (rm_illegal),
        .fcsr_o       (fcsr_o)
    );

    fma_sequencer fma_sequencer_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .req_i     (req_i),
        .stall_i   (stall_i),
        .expired_i (expired),
        .accept_o  (accept),
        .capture_o (capture),
        .ready_o   (ready_o),
        .busy_o    (busy_o)
    );

    fma_latency_timer #(
        .FMA_LATENCY (FMA_LATENCY)
    ) fma_latency_timer_i (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .start_i   (accept),
        .stall_i   (stall_i),
        .expired_o (expired)
    );

    // Multicycle path from ops_q to result_q
    fma_core fma_core_i (
        .ops_i    (ops_q),
        .result_o (core_result)
    );

    ////////////////////////////////////////////////////////////
    // Operand and result registers
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (accept) begin
            ops_q <= '{a: a_i, b: b_i, c: c_i, rm: rm_eff};
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            illegal_q <= 1'b0;
        end else if (accept) begin
            illegal_q <= rm_illegal;
        end
    end

    always_ff @(posedge clk_i) begin
        if (capture) begin
            result_q.value <= illegal_q ? CANON_NAN : core_result.value;
            result_q.flags <= illegal_q ? fflags_t'(0) : core_result.flags;
        end
    end

    assign result_o     = result_q.value;
    assign flags_o      = result_q.flags;
    assign illegal_rm_o = ready_o & illegal_q;

endmodule

//--- verilog/fma_fcsr.sv
`timescale 1ns/100ps

module fma_fcsr (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             csr_we_i,
    input  fma_pkg::fcsr_t   csr_wdata_i,
    input  fma_pkg::rm_t     rm_i,
    input  logic             accrue_i,
    input  fma_pkg::fflags_t flags_i,
    output fma_pkg::rm_t     rm_eff_o,
    output logic             rm_illegal_o,
    output fma_pkg::fcsr_t   fcsr_o
);
    import fma_pkg::*;

    rm_t     frm;
    fflags_t fflags;
    fflags_t fflags_next;

    always_comb begin
        fflags_next = csr_we_i ? csr_wdata_i.fflags : fflags;
        if (accrue_i) begin
            fflags_next = fflags_next | flags_i;
        end
        // DZ never occurs in FMA
        fflags_next[FLAG_DZ] = 1'b0;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            frm    <= RM_RNE;
            fflags <= '0;
        end else begin
            if (csr_we_i) begin
                frm <= csr_wdata_i.frm;
            end
            fflags <= fflags_next;
        end
    end

    // DYN in the instruction selects frm
    assign rm_eff_o     = (rm_i == RM_DYN) ? frm : rm_i;
    // Reserved codes and DYN held in frm
    assign rm_illegal_o = (rm_eff_o > RM_RMM);
    assign fcsr_o       = '{frm: frm, fflags: fflags};

endmodule

//--- verilog/fma_sequencer.sv
`timescale 1ns/100ps

module fma_sequencer (
    input  logic clk_i,
    input  logic rst_i,
    input  logic req_i,
    input  logic stall_i,
    input  logic expired_i,
    output logic accept_o,
    output logic capture_o,
    output logic ready_o,
    output logic busy_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        DONE
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        accept_o   = 1'b0;
        capture_o  = 1'b0;
        case (state)
            IDLE: begin
                if (req_i) begin
                    accept_o   = 1'b1;
                    state_next = WAIT;
                end
            end
            WAIT: begin
                // Core result is settled, load it this edge
                if (expired_i) begin
                    capture_o  = 1'b1;
                    state_next = DONE;
                end
            end
            DONE: begin
                // Result consumed, a new request may follow at once
                if (!stall_i) begin
                    accept_o   = req_i;
                    state_next = req_i ? WAIT : IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    assign ready_o = (state == DONE);
    // Free again once the result is taken
    assign busy_o  = (state == WAIT) | ((state == DONE) & stall_i);

endmodule

//--- verilog/fma_latency_timer.sv
`timescale 1ns/100ps

module fma_latency_timer #(
    parameter int FMA_LATENCY = 3
) (
    input  logic clk_i,
    input  logic rst_i,
    input  logic start_i,
    input  logic stall_i,
    output logic expired_o
);

    // Remaining edges before the result may be captured
    logic [3:0] count;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            count <= 4'd0;
        end else if (start_i) begin
            count <= 4'(FMA_LATENCY);
        end else if (!stall_i && count != 4'd0) begin
            count <= count - 4'd1;
        end
    end

    // Last step, held back while stalled
    assign expired_o = (count == 4'd1) && !stall_i;

endmodule

//--- verilog/fma_core.sv
`timescale 1ns/100ps

module fma_core (
    input  fma_pkg::fma_operands_t ops_i,
    output fma_pkg::fma_result_t   result_o
);
    import fma_pkg::*;

    typedef logic signed [11:0] sexp_t;

    fp_class_t   a_cls;
    fp_class_t   b_cls;
    fp_class_t   c_cls;
    logic        special;
    logic        invalid;
    fp32_t       special_value;
    logic        a_sign;
    logic        p_sign;
    logic        eff_sub;
    logic        prod_big;
    logic        big_sign;
    logic        res_sign;
    logic [23:0] a_man;
    logic [23:0] b_man;
    logic [23:0] c_man;
    logic [47:0] p_man;
    logic [47:0] big_man;
    logic [47:0] small_man;
    sexp_t       a_exp;
    sexp_t       p_exp;
    sexp_t       big_exp;
    sexp_t       exp_gap;
    sexp_t       norm_exp;
    sexp_t       exp_n;
    sexp_t       shl;
    logic [6:0]  align_sh;
    logic [6:0]  rsh;
    logic [6:0]  lead;
    logic        align_sticky;
    logic        norm_sticky;
    logic [99:0] small_full;
    logic [99:0] small_shift;
    logic [99:0] small_f;
    logic [99:0] big_f;
    logic [99:0] mag;
    logic [99:0] norm;
    logic        round_sticky;
    logic        inexact;
    logic        round_up;
    logic        tiny_up;
    logic        tiny;
    logic        overflow;
    logic        ovf_inf;
    logic [7:0]  exp_enc;
    logic [30:0] rounded;
    fp32_t       res_value;
    fflags_t     res_flags;

    // Hidden bit set for any nonzero exponent
    function automatic logic [23:0] mant_of(fp32_t x);
        return {|x[FRAC_W +: EXP_W], x[FRAC_W-1:0]};
    endfunction

    // Denormals share the scale of exponent 1
    function automatic sexp_t exp_of(fp32_t x);
        return (x[FRAC_W +: EXP_W] == '0) ? sexp_t'(1) : sexp_t'({4'd0, x[FRAC_W +: EXP_W]});
    endfunction

    function automatic logic round_inc(rm_t rm, logic sign, logic lsb, logic guard, logic sticky);
        logic up;
        case (rm)
            RM_RTZ:  up = 1'b0;
            RM_RDN:  up = sign & (guard | sticky);
            RM_RUP:  up = !sign & (guard | sticky);
            RM_RMM:  up = guard;
            // Ties to even
            default: up = guard & (sticky | lsb);
        endcase
        return up;
    endfunction

    fma_special_case fma_special_case_i (
        .a_i             (ops_i.a),
        .b_i             (ops_i.b),
        .c_i             (ops_i.c),
        .a_class_o       (a_cls),
        .b_class_o       (b_cls),
        .c_class_o       (c_cls),
        .special_o       (special),
        .special_value_o (special_value),
        .invalid_o       (invalid)
    );

    ////////////////////////////////////////////////////////////
    // Unpack, multiply and align
    ////////////////////////////////////////////////////////////
    always_comb begin
        a_man   = mant_of(ops_i.a);
        b_man   = mant_of(ops_i.b);
        c_man   = mant_of(ops_i.c);
        a_exp   = exp_of(ops_i.a);
        // Exact product, binary point after bit 46
        p_man   = 48'(b_man) * 48'(c_man);
        p_exp   = exp_of(ops_i.b) + exp_of(ops_i.c) - sexp_t'(BIAS);
        a_sign  = ops_i.a[31];
        p_sign  = ops_i.b[31] ^ ops_i.c[31];
        eff_sub = a_sign ^ p_sign;
        // A zero operand always takes the small side
        prod_big = a_cls.is_zero | (!(b_cls.is_zero | c_cls.is_zero) & (p_exp >= a_exp));
        big_man   = prod_big ? p_man : {1'b0, a_man, 23'd0};
        small_man = prod_big ? {1'b0, a_man, 23'd0} : p_man;
        big_exp   = prod_big ? p_exp : a_exp;
        big_sign  = prod_big ? p_sign : a_sign;
        exp_gap   = prod_big ? p_exp - a_exp : a_exp - p_exp;
        if (exp_gap < 0) begin
            align_sh = 7'd0;
        end else if (exp_gap > 127) begin
            align_sh = 7'd127;
        end else begin
            align_sh = exp_gap[6:0];
        end
        // Field point sits after bit 97, bit 99 is carry headroom
        big_f        = {1'b0, big_man, 51'd0};
        small_full   = {1'b0, small_man, 51'd0};
        small_shift  = small_full >> align_sh;
        align_sticky = (small_shift << align_sh) != small_full;
        // Lost bits jammed into the field LSB
        small_f = small_shift | {99'd0, align_sticky};
    end

    ////////////////////////////////////////////////////////////
    // Magnitude add and normalize
    ////////////////////////////////////////////////////////////
    always_comb begin
        if (eff_sub) begin
            mag      = big_f - small_f;
            res_sign = big_sign ^ mag[99];
            if (mag[99]) begin
                mag = -mag;
            end
        end else begin
            mag      = big_f + small_f;
            res_sign = big_sign;
        end
        lead = 7'd0;
        for (int i = 0; i < 100; i++) begin
            if (mag[i]) begin
                lead = 7'(i);
            end
        end
        // Exponent once the leading one reaches bit 99
        norm_exp = big_exp + sexp_t'(lead) - sexp_t'(97);
        if (norm_exp >= 1) begin
            shl   = sexp_t'(99) - sexp_t'(lead);
            exp_n = norm_exp;
        end else begin
            // Tiny result stops at the minimum exponent
            shl   = big_exp + sexp_t'(1);
            exp_n = sexp_t'(1);
        end
        if (shl >= 0) begin
            rsh         = 7'd0;
            norm        = mag << shl[6:0];
            norm_sticky = 1'b0;
        end else begin
            rsh         = (shl < -127) ? 7'd127 : 7'(-shl);
            norm        = mag >> rsh;
            norm_sticky = (norm << rsh) != mag;
        end
    end

    ////////////////////////////////////////////////////////////
    // Round and pack
    ////////////////////////////////////////////////////////////
    always_comb begin
        // Kept bits 99:76, guard 75
        round_sticky = |norm[74:0] | norm_sticky;
        inexact      = norm[75] | round_sticky;
        round_up     = round_inc(ops_i.rm, res_sign, norm[76], norm[75], round_sticky);
        exp_enc      = norm[99] ? exp_n[7:0] : 8'd0;
        // Mantissa carry ripples into the exponent field
        rounded  = {exp_enc, norm[98:76]} + 31'(round_up);
        overflow = (exp_n > 254) | (rounded[30:23] == 8'hff);
        // Tininess judged with one more bit of precision
        tiny_up = round_inc(ops_i.rm, res_sign, norm[75], norm[74],
                            |norm[73:0] | norm_sticky);
        tiny    = !norm[99] & !(&norm[98:75] & tiny_up);
        case (ops_i.rm)
            RM_RTZ:  ovf_inf = 1'b0;
            RM_RDN:  ovf_inf = res_sign;
            RM_RUP:  ovf_inf = !res_sign;
            default: ovf_inf = 1'b1;
        endcase
        res_flags = '0;
        if (special) begin
            res_value          = special_value;
            res_flags[FLAG_NV] = invalid;
        end else if (mag == '0) begin
            // Exact cancellation gives +0 except in RDN
            res_value = {eff_sub ? (ops_i.rm == RM_RDN) : a_sign, 31'd0};
        end else if (overflow) begin
            res_value          = {res_sign, ovf_inf ? 31'h7f800000 : 31'h7f7fffff};
            res_flags[FLAG_OF] = 1'b1;
            res_flags[FLAG_NX] = 1'b1;
        end else begin
            res_value          = {res_sign, rounded};
            res_flags[FLAG_UF] = tiny & inexact;
            res_flags[FLAG_NX] = inexact;
        end
    end

    assign result_o = '{value: res_value, flags: res_flags};

endmodule

//--- verilog/fma_special_case.sv
`timescale 1ns/100ps

module fma_special_case (
    input  fma_pkg::fp32_t     a_i,
    input  fma_pkg::fp32_t     b_i,
    input  fma_pkg::fp32_t     c_i,
    output fma_pkg::fp_class_t a_class_o,
    output fma_pkg::fp_class_t b_class_o,
    output fma_pkg::fp_class_t c_class_o,
    output logic               special_o,
    output fma_pkg::fp32_t     special_value_o,
    output logic               invalid_o
);
    import fma_pkg::*;

    logic prod_sign;
    logic prod_inf;
    logic any_nan;
    logic any_snan;
    logic inf_times_zero;
    logic inf_cancel;

    // Decode one binary32 word from its exponent and fraction fields
    function automatic fp_class_t classify(fp32_t x);
        fp_class_t cls;
        logic      exp_max;
        logic      exp_zero;
        logic      frac_zero;
        exp_max       = &x[FRAC_W +: EXP_W];
        exp_zero      = ~|x[FRAC_W +: EXP_W];
        frac_zero     = ~|x[FRAC_W-1:0];
        cls.is_zero   = exp_zero & frac_zero;
        cls.is_inf    = exp_max & frac_zero;
        cls.is_nan    = exp_max & !frac_zero;
        // Quiet bit is the fraction MSB
        cls.is_snan   = exp_max & !frac_zero & !x[FRAC_W-1];
        cls.is_denorm = exp_zero & !frac_zero;
        return cls;
    endfunction

    assign a_class_o = classify(a_i);
    assign b_class_o = classify(b_i);
    assign c_class_o = classify(c_i);

    assign prod_sign = b_i[31] ^ c_i[31];
    assign prod_inf  = b_class_o.is_inf | c_class_o.is_inf;
    assign any_nan   = a_class_o.is_nan | b_class_o.is_nan | c_class_o.is_nan;
    assign any_snan  = a_class_o.is_snan | b_class_o.is_snan | c_class_o.is_snan;

    // Infinity times zero in the product
    assign inf_times_zero = (b_class_o.is_inf & c_class_o.is_zero) |
                            (c_class_o.is_inf & b_class_o.is_zero);
    // Infinite product against an opposite infinite addend
    assign inf_cancel = prod_inf & a_class_o.is_inf & (a_i[31] != prod_sign);

    assign special_o = any_nan | inf_times_zero | prod_inf | a_class_o.is_inf;
    assign invalid_o = any_snan | inf_times_zero | (inf_cancel & !any_nan);

    always_comb begin
        special_value_o = CANON_NAN;
        if (!(any_nan | inf_times_zero | inf_cancel)) begin
            // Infinite product wins over a same-signed infinite addend
            if (prod_inf) begin
                special_value_o = {prod_sign, 8'hff, 23'd0};
            end else begin
                special_value_o = {a_i[31], 8'hff, 23'd0};
            end
        end
    end

endmodule

//--- verilog/fma_pkg.sv
package fma_pkg;

    // Binary32 field widths and exponent bias
    localparam int EXP_W  = 8;
    localparam int FRAC_W = 23;
    localparam int BIAS   = 127;

    typedef logic [31:0] fp32_t;
    typedef logic [2:0]  rm_t;
    typedef logic [4:0]  fflags_t;

    // Rounding mode codes
    // Codes 101 and 110 are reserved
    localparam rm_t RM_RNE = 3'b000;
    localparam rm_t RM_RTZ = 3'b001;
    localparam rm_t RM_RDN = 3'b010;
    localparam rm_t RM_RUP = 3'b011;
    localparam rm_t RM_RMM = 3'b100;
    localparam rm_t RM_DYN = 3'b111;

    // Bit positions inside fflags
    localparam int FLAG_NV = 4;
    localparam int FLAG_DZ = 3;
    localparam int FLAG_OF = 2;
    localparam int FLAG_UF = 1;
    localparam int FLAG_NX = 0;

    localparam fp32_t CANON_NAN = 32'h7fc00000;

    typedef struct packed {
        rm_t     frm;
        fflags_t fflags;
    } fcsr_t;

    // Operands with the rounding mode already resolved
    typedef struct packed {
        fp32_t a;
        fp32_t b;
        fp32_t c;
        rm_t   rm;
    } fma_operands_t;

    typedef struct packed {
        fp32_t   value;
        fflags_t flags;
    } fma_result_t;

    typedef struct packed {
        logic is_zero;
        logic is_inf;
        logic is_nan;
        logic is_snan;
        logic is_denorm;
    } fp_class_t;

endpackage
